//--- hw/memCtrl_cfg.svh
`ifndef MEMCTRL_CFG_SVH
`define MEMCTRL_CFG_SVH

// byte address width
`define MC_ADDR_W 32

// RAM is one byte wide
`define MC_BYTE_W 8

// bytes in one CPU word
`define MC_WORD_BYTES 4

// beat index and beat counter width
`define MC_BEAT_W 3

`endif

//--- hw/memBusPkg.sv
`include "memCtrl_cfg.svh"

package memBusPkg;

    // byte address on the RAM port
    typedef logic [`MC_ADDR_W-1:0] memAddr_t;

    // one byte of RAM data
    typedef logic [`MC_BYTE_W-1:0] memByte_t;

    // RAM direction
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } memRw_e;

endpackage

//--- hw/reqPkg.sv
`include "memCtrl_cfg.svh"

package reqPkg;

    // value is the number of bytes moved
    typedef enum logic [2:0] {
        LEN_BYTE = 3'd1,
        LEN_HALF = 3'd2,
        LEN_WORD = 3'd4
    } accLen_e;

    // requester currently served by the sequencer
    typedef enum logic [1:0] {
        OWN_NONE  = 2'd0,
        OWN_DATA  = 2'd1,
        OWN_FETCH = 2'd2
    } owner_e;

    // a word seen whole or as little-endian bytes
    // bytes[0] is the lowest address
    typedef union packed {
        logic [`MC_WORD_BYTES*`MC_BYTE_W-1:0]          word;
        memBusPkg::memByte_t [`MC_WORD_BYTES-1:0]      bytes;
    } dataWord_u;

endpackage

//--- hw/accessSequencer.sv
`timescale 1ns/1ns
`include "memCtrl_cfg.svh"

module accessSequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_rdy,
    input  logic                  i_fetchEn,
    input  memBusPkg::memAddr_t   i_fetchAddr,
    input  logic                  i_dataEn,
    input  logic                  i_dataStore,
    input  reqPkg::accLen_e       i_dataLen,
    input  memBusPkg::memAddr_t   i_dataAddr,
    input  reqPkg::dataWord_u     i_dataWdata,
    output reqPkg::owner_e        o_owner,
    output memBusPkg::memRw_e     o_memRw,
    output memBusPkg::memAddr_t   o_memAddr,
    output memBusPkg::memByte_t   o_memWdata,
    output logic                  o_beatValid,
    output logic [`MC_BEAT_W-1:0] o_beatIdx,
    output logic                  o_beatLast,
    output logic                  o_beatRead,
    output logic                  o_beatFetch
);

    localparam int SelW = $clog2(`MC_WORD_BYTES);

    // latched request
    memBusPkg::memAddr_t   baseAddr;
    reqPkg::accLen_e       lenQ;
    logic                  isWrite;
    reqPkg::dataWord_u     storeWord;
    logic [`MC_BEAT_W-1:0] beatCnt;
    memBusPkg::memRw_e     memRwQ;

    // beat about to be issued
    logic                  accept;
    logic                  issue;
    logic                  finish;
    memBusPkg::memAddr_t   curAddr;
    reqPkg::accLen_e       curLen;
    logic                  curWrite;
    logic                  curFetch;
    reqPkg::dataWord_u     curWord;
    logic [`MC_BEAT_W-1:0] curIdx;
    logic [`MC_BEAT_W-1:0] nextIdx;

    always_comb begin
        accept = i_rdy && (o_owner == reqPkg::OWN_NONE) && (i_dataEn || i_fetchEn);
        finish = (o_owner != reqPkg::OWN_NONE) && (beatCnt == lenQ);
        if (o_owner == reqPkg::OWN_NONE) begin
            // data side wins a tie
            curAddr  = i_dataEn ? i_dataAddr : i_fetchAddr;
            curLen   = i_dataEn ? i_dataLen : reqPkg::LEN_WORD;
            curWrite = i_dataEn && i_dataStore;
            curFetch = !i_dataEn;
            curWord  = i_dataWdata;
            curIdx   = '0;
        end else begin
            curAddr  = baseAddr;
            curLen   = lenQ;
            curWrite = isWrite;
            curFetch = (o_owner == reqPkg::OWN_FETCH);
            curWord  = storeWord;
            curIdx   = beatCnt;
        end
        nextIdx = curIdx + 1'b1;
        issue   = accept || ((o_owner != reqPkg::OWN_NONE) && !finish);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_owner     <= reqPkg::OWN_NONE;
            o_beatValid <= 1'b0;
            memRwQ      <= memBusPkg::MEM_READ;
            beatCnt     <= '0;
        end else if (i_rdy) begin
            o_beatValid <= issue;
            memRwQ      <= (issue && curWrite) ? memBusPkg::MEM_WRITE : memBusPkg::MEM_READ;
            if (issue) begin
                beatCnt <= nextIdx;
            end
            if (accept) begin
                o_owner <= i_dataEn ? reqPkg::OWN_DATA : reqPkg::OWN_FETCH;
            end else if (finish) begin
                // frees the port while the last byte is still in flight
                o_owner <= reqPkg::OWN_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rdy) begin
            if (accept) begin
                baseAddr  <= curAddr;
                lenQ      <= curLen;
                isWrite   <= curWrite;
                storeWord <= curWord;
            end
            if (issue) begin
                o_memAddr   <= curAddr + memBusPkg::memAddr_t'(curIdx);
                o_memWdata  <= curWord.bytes[curIdx[SelW-1:0]];
                o_beatIdx   <= curIdx;
                o_beatLast  <= (nextIdx == curLen);
                o_beatRead  <= !curWrite;
                o_beatFetch <= curFetch;
            end
        end
    end

    // no write strobe reaches the RAM during a hold
    assign o_memRw = i_rdy ? memRwQ : memBusPkg::MEM_READ;

    beatIdxInRange: assert property (@(posedge clk) disable iff (rst)
        o_beatValid |-> (o_beatIdx < lenQ))
        else $error("beat index %0d not below length %0d", o_beatIdx, lenQ);

    writeNotFetch: assert property (@(posedge clk) disable iff (rst)
        (o_beatValid && !o_beatRead) |-> !o_beatFetch)
        else $error("write beat tagged as fetch");

endmodule

//--- hw/wordAssembler.sv
`timescale 1ns/1ns
`include "memCtrl_cfg.svh"

module wordAssembler (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_rdy,
    input  memBusPkg::memByte_t   i_memRdata,
    input  logic                  i_beatValid,
    input  logic [`MC_BEAT_W-1:0] i_beatIdx,
    input  logic                  i_beatLast,
    input  logic                  i_beatRead,
    input  logic                  i_beatFetch,
    output logic                  o_fetchDone,
    output reqPkg::dataWord_u     o_fetchInst,
    output logic                  o_dataDone,
    output reqPkg::dataWord_u     o_dataRdata
);

    localparam int SelW = $clog2(`MC_WORD_BYTES);

    // beat tags one cycle late to line up with the RAM read data
    logic                  alValid;
    logic [`MC_BEAT_W-1:0] alIdx;
    logic                  alLast;
    logic                  alRead;
    logic                  alFetch;

    reqPkg::dataWord_u     byteBuf;
    reqPkg::dataWord_u     assembled;
    logic                  lastBeat;

    always_ff @(posedge clk) begin
        if (rst) begin
            alValid <= 1'b0;
        end else if (i_rdy) begin
            alValid <= i_beatValid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rdy) begin
            alIdx   <= i_beatIdx;
            alLast  <= i_beatLast;
            alRead  <= i_beatRead;
            alFetch <= i_beatFetch;
        end
    end

    // first beat starts from zero so short loads come out zero-extended
    always_comb begin
        if (alIdx == '0) begin
            assembled.word = '0;
        end else begin
            assembled = byteBuf;
        end
        assembled.bytes[alIdx[SelW-1:0]] = i_memRdata;
    end

    always_ff @(posedge clk) begin
        if (i_rdy && alValid && alRead) begin
            byteBuf <= assembled;
        end
    end

    assign lastBeat = alValid && alLast && i_rdy;

    assign o_fetchDone = lastBeat && alFetch;
    assign o_dataDone  = lastBeat && !alFetch;
    assign o_fetchInst = assembled;
    assign o_dataRdata = assembled;

    oneDoneOnly: assert property (@(posedge clk) disable iff (rst)
        !(o_fetchDone && o_dataDone))
        else $error("fetch and data done in the same cycle");

endmodule

//--- hw/memCtrl.sv
`timescale 1ns/1ns
`include "memCtrl_cfg.svh"

module memCtrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                i_rdy,
    // fetch side
    input  logic                i_fetchEn,
    input  memBusPkg::memAddr_t i_fetchAddr,
    output logic                o_fetchDone,
    output reqPkg::dataWord_u   o_fetchInst,
    // data side
    input  logic                i_dataEn,
    input  logic                i_dataStore,
    input  reqPkg::accLen_e     i_dataLen,
    input  memBusPkg::memAddr_t i_dataAddr,
    input  reqPkg::dataWord_u   i_dataWdata,
    output logic                o_dataDone,
    output reqPkg::dataWord_u   o_dataRdata,
    // byte RAM
    input  memBusPkg::memByte_t i_memRdata,
    output memBusPkg::memRw_e   o_memRw,
    output memBusPkg::memAddr_t o_memAddr,
    output memBusPkg::memByte_t o_memWdata,
    output reqPkg::owner_e      o_owner
);

    logic                  beatValid;
    logic [`MC_BEAT_W-1:0] beatIdx;
    logic                  beatLast;
    logic                  beatRead;
    logic                  beatFetch;

    accessSequencer seq0 (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_owner     (o_owner),
        .o_memRw     (o_memRw),
        .o_memAddr   (o_memAddr),
        .o_memWdata  (o_memWdata),
        .o_beatValid (beatValid),
        .o_beatIdx   (beatIdx),
        .o_beatLast  (beatLast),
        .o_beatRead  (beatRead),
        .o_beatFetch (beatFetch)
    );

    wordAssembler asm0 (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_memRdata  (i_memRdata),
        .i_beatValid (beatValid),
        .i_beatIdx   (beatIdx),
        .i_beatLast  (beatLast),
        .i_beatRead  (beatRead),
        .i_beatFetch (beatFetch),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata)
    );

endmodule

//--- testbench/tbRamModel.sv
`timescale 1ns/1ns
`include "memCtrl_cfg.svh"

module tbRamModel #(
    parameter int Depth = 256
) (
    input  logic                clk,
    input  logic                i_rdy,
    input  memBusPkg::memRw_e   i_rw,
    input  memBusPkg::memAddr_t i_addr,
    input  memBusPkg::memByte_t i_wdata,
    output memBusPkg::memByte_t o_rdata
);

    localparam int AddrW = $clog2(Depth);

    // filled by the testbench before reset ends
    memBusPkg::memByte_t mem [Depth];

    // one cycle read latency and nothing moves while held
    always @(posedge clk) begin
        if (i_rdy) begin
            if (i_rw == memBusPkg::MEM_WRITE) begin
                mem[i_addr[AddrW-1:0]] <= i_wdata;
            end
            o_rdata <= mem[i_addr[AddrW-1:0]];
        end
    end

endmodule

//--- testbench/tbMemCtrl.sv
`timescale 1ns/1ns
`include "memCtrl_cfg.svh"

module tbMemCtrl;

    localparam int NumTests  = 40;
    localparam int TestCyc   = 14;
    localparam int TimeoutNs = (16 + NumTests * TestCyc + 100) * 10;

    logic clk;
    logic rst;
    logic i_rdy;
    logic i_fetchEn;
    logic i_dataEn;
    logic i_dataStore;
    memBusPkg::memAddr_t i_fetchAddr;
    memBusPkg::memAddr_t i_dataAddr;
    reqPkg::accLen_e     i_dataLen;
    reqPkg::dataWord_u   i_dataWdata;
    memBusPkg::memByte_t i_memRdata;
    memBusPkg::memRw_e   o_memRw;
    memBusPkg::memAddr_t o_memAddr;
    memBusPkg::memByte_t o_memWdata;
    reqPkg::owner_e      o_owner;
    logic                o_fetchDone;
    logic                o_dataDone;
    reqPkg::dataWord_u   o_fetchInst;
    reqPkg::dataWord_u   o_dataRdata;

    logic [31:0] lfsr = 32'h004c_023e;
    memBusPkg::memByte_t refMem [256];
    int valueErrs = 0;
    int resetErrs = 0;

    // expected controller state stepped by the timing rules
    reqPkg::owner_e      mOwner;
    logic [2:0]          mCnt;
    logic [2:0]          mLen;
    memBusPkg::memAddr_t mBase;
    logic                mWrite;
    logic [31:0]         mStore;
    logic [31:0]         mWord;
    logic                mValid;
    logic                mWr;
    memBusPkg::memAddr_t mAddr;
    memBusPkg::memByte_t mWdata;
    logic                mDone;
    logic                mDoneFetch;
    logic                mDoneRead;
    logic [31:0]         mDoneWord;

    memBusPkg::memRw_e expRw;
    logic              expFetchDone;
    logic              expDataDone;

    memCtrl dut0 (.*);

    tbRamModel ram0 (
        .clk     (clk),
        .i_rdy   (i_rdy),
        .i_rw    (o_memRw),
        .i_addr  (o_memAddr),
        .i_wdata (o_memWdata),
        .o_rdata (i_memRdata)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] rnd(input int nBits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nBits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // little-endian with zero above n bytes
    function automatic logic [31:0] readRef(input memBusPkg::memAddr_t addr, input int n);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < n; k++) begin
            w[8*k +: 8] = refMem[8'(addr + k)];
        end
        return w;
    endfunction

    always @(posedge clk) begin
        logic [2:0]          len;
        memBusPkg::memAddr_t base;
        logic                wr;
        if (rst) begin
            mOwner <= reqPkg::OWN_NONE;
            mValid <= 1'b0;
            mDone  <= 1'b0;
            mCnt   <= '0;
        end else if (i_rdy) begin
            mValid <= 1'b0;
            mWr    <= 1'b0;
            mDone  <= 1'b0;
            if (mOwner == reqPkg::OWN_NONE) begin
                if (i_dataEn || i_fetchEn) begin
                    len  = i_dataEn ? 3'(i_dataLen) : 3'd4;
                    base = i_dataEn ? i_dataAddr : i_fetchAddr;
                    wr   = i_dataEn && i_dataStore;
                    if (wr) begin
                        for (int k = 0; k < len; k++) begin
                            refMem[8'(base + k)] = i_dataWdata.word[8*k +: 8];
                        end
                    end
                    mOwner <= i_dataEn ? reqPkg::OWN_DATA : reqPkg::OWN_FETCH;
                    mLen   <= len;
                    mBase  <= base;
                    mWrite <= wr;
                    mStore <= i_dataWdata.word;
                    mWord  <= readRef(base, len);
                    mValid <= 1'b1;
                    mWr    <= wr;
                    mAddr  <= base;
                    mWdata <= i_dataWdata.word[7:0];
                    mCnt   <= 3'd1;
                end
            end else if (mCnt == mLen) begin
                mDone      <= 1'b1;
                mDoneFetch <= (mOwner == reqPkg::OWN_FETCH);
                mDoneRead  <= !mWrite;
                mDoneWord  <= mWord;
                mOwner     <= reqPkg::OWN_NONE;
            end else begin
                mValid <= 1'b1;
                mWr    <= mWrite;
                mAddr  <= mBase + memBusPkg::memAddr_t'(mCnt);
                mWdata <= mStore[8*mCnt +: 8];
                mCnt   <= mCnt + 1'b1;
            end
        end
    end

    assign expRw        = (i_rdy && mValid && mWr) ? memBusPkg::MEM_WRITE : memBusPkg::MEM_READ;
    assign expFetchDone = i_rdy && mDone && mDoneFetch;
    assign expDataDone  = i_rdy && mDone && !mDoneFetch;

    resetIdle: assert property (@(posedge clk) rst |=> (o_owner == reqPkg::OWN_NONE
            && o_memRw == memBusPkg::MEM_READ && !o_fetchDone && !o_dataDone))
        else begin
            resetErrs++;
            $display("** Error: reset state o_owner %h o_memRw %h o_fetchDone %h o_dataDone %h",
                $sampled(o_owner), $sampled(o_memRw), $sampled(o_fetchDone),
                $sampled(o_dataDone));
        end

    ownerMatch: assert property (@(posedge clk) disable iff (rst) o_owner == mOwner)
        else begin
            valueErrs++;
            $display("** Error: o_owner is %h, expected %h", $sampled(o_owner), $sampled(mOwner));
        end

    rwMatch: assert property (@(posedge clk) disable iff (rst) o_memRw == expRw)
        else begin
            valueErrs++;
            $display("** Error: o_memRw is %h, expected %h", $sampled(o_memRw), $sampled(expRw));
        end

    addrMatch: assert property (@(posedge clk) disable iff (rst)
            (i_rdy && mValid) |-> o_memAddr == mAddr)
        else begin
            valueErrs++;
            $display("** Error: o_memAddr is %h, expected %h",
                $sampled(o_memAddr), $sampled(mAddr));
        end

    wdataMatch: assert property (@(posedge clk) disable iff (rst)
            (i_rdy && mValid && mWr) |-> o_memWdata == mWdata)
        else begin
            valueErrs++;
            $display("** Error: o_memWdata is %h, expected %h",
                $sampled(o_memWdata), $sampled(mWdata));
        end

    fetchDoneMatch: assert property (@(posedge clk) disable iff (rst) o_fetchDone == expFetchDone)
        else begin
            valueErrs++;
            $display("** Error: o_fetchDone is %h, expected %h",
                $sampled(o_fetchDone), $sampled(expFetchDone));
        end

    dataDoneMatch: assert property (@(posedge clk) disable iff (rst) o_dataDone == expDataDone)
        else begin
            valueErrs++;
            $display("** Error: o_dataDone is %h, expected %h",
                $sampled(o_dataDone), $sampled(expDataDone));
        end

    instMatch: assert property (@(posedge clk) disable iff (rst)
            o_fetchDone |-> o_fetchInst.word == mDoneWord)
        else begin
            valueErrs++;
            $display("** Error: o_fetchInst is %h, expected %h",
                $sampled(o_fetchInst.word), $sampled(mDoneWord));
        end

    rdataMatch: assert property (@(posedge clk) disable iff (rst)
            (o_dataDone && mDoneRead) |-> o_dataRdata.word == mDoneWord)
        else begin
            valueErrs++;
            $display("** Error: o_dataRdata is %h, expected %h",
                $sampled(o_dataRdata.word), $sampled(mDoneWord));
        end

    // called on a falling edge and holds i_rdy low for hold cycles after acceptance
    // the side that is not meant to win gets the inverted address
    task automatic runAccess(input logic fetch, input logic data, input logic store,
                             input logic [2:0] len, input logic [31:0] addr,
                             input logic [31:0] wdata, input int hold);
        while (o_owner != reqPkg::OWN_NONE) begin
            @(negedge clk);
        end
        i_fetchEn        = fetch;
        i_fetchAddr      = data ? ~addr : addr;
        i_dataEn         = data;
        i_dataStore      = store;
        i_dataLen        = reqPkg::accLen_e'(len);
        i_dataAddr       = data ? addr : ~addr;
        i_dataWdata.word = wdata;
        @(negedge clk);
        i_fetchEn = 1'b0;
        i_dataEn  = 1'b0;
        if (hold > 0) begin
            i_rdy = 1'b0;
            repeat (hold) @(negedge clk);
            i_rdy = 1'b1;
        end
    endtask

    initial begin
        #(TimeoutNs);
        $display("watchdog expired, an access never completed");
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int          kind;
        logic [2:0]  len;
        logic [31:0] addr;
        logic [31:0] wdata;
        int          hold;
        clk              = 1'b0;
        rst              = 1'b1;
        i_rdy            = 1'b1;
        i_fetchEn        = 1'b0;
        i_dataEn         = 1'b0;
        i_dataStore      = 1'b0;
        i_fetchAddr      = '0;
        i_dataAddr       = '0;
        i_dataLen        = reqPkg::LEN_BYTE;
        i_dataWdata.word = '0;
        for (int i = 0; i < 256; i++) begin
            refMem[i]   = 8'((i * 73) ^ (i >> 3) ^ 8'h5a);
            ram0.mem[i] = 8'((i * 73) ^ (i >> 3) ^ 8'h5a);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        runAccess(1, 0, 0, 3'd4, 32'h10, 32'h0, 0);
        runAccess(0, 1, 0, 3'd1, 32'h21, 32'h0, 0);
        runAccess(0, 1, 0, 3'd2, 32'h32, 32'h0, 0);
        runAccess(0, 1, 0, 3'd4, 32'h43, 32'h0, 0);
        runAccess(0, 1, 1, 3'd1, 32'h50, 32'hdead_beef, 0);
        runAccess(1, 0, 0, 3'd4, 32'h50, 32'h0, 0);
        runAccess(0, 1, 1, 3'd2, 32'h60, 32'hcafe_f00d, 0);
        runAccess(0, 1, 0, 3'd4, 32'h60, 32'h0, 0);
        runAccess(0, 1, 1, 3'd4, 32'h70, 32'h1234_5678, 0);
        runAccess(0, 1, 0, 3'd2, 32'h72, 32'h0, 0);
        // both strobes together and the data side wins
        runAccess(1, 1, 0, 3'd2, 32'h80, 32'h0, 0);
        runAccess(1, 1, 1, 3'd4, 32'h84, 32'h0bad_cafe, 0);
        runAccess(1, 0, 0, 3'd4, 32'h90, 32'h0, 3);
        runAccess(0, 1, 1, 3'd4, 32'ha0, 32'h89ab_cdef, 2);
        runAccess(0, 1, 0, 3'd4, 32'ha0, 32'h0, 1);

        for (int t = 15; t < NumTests; t++) begin
            kind  = int'(rnd(2));
            len   = (rnd(2) == 0) ? 3'd1 : ((rnd(1) == 0) ? 3'd2 : 3'd4);
            addr  = rnd(8);
            wdata = rnd(32);
            hold  = (rnd(1) == 1) ? int'(rnd(2)) : 0;
            runAccess(kind == 0 || kind == 3, kind != 0, kind == 2, len, addr, wdata, hold);
        end
        while (o_owner != reqPkg::OWN_NONE) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        $display("errors: value %0d, reset %0d", valueErrs, resetErrs);
        if (valueErrs == 0 && resetErrs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- memCtrl.f
+incdir+hw
hw/memBusPkg.sv
hw/reqPkg.sv
hw/accessSequencer.sv
hw/wordAssembler.sv
hw/memCtrl.sv
testbench/tbRamModel.sv
testbench/tbMemCtrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tbMemCtrl -f memCtrl.f \
    --Mdir build -o simMemCtrl

./build/simMemCtrl > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1
